/* hdl/gf_pkg.sv */
package gf_pkg;

	typedef logic [7:0] gf_elem;                    // one GF(2^8) symbol

	localparam logic [8:0] gf_poly = 9'h11D;        // x^8 + x^4 + x^3 + x^2 + 1
	localparam gf_elem gf_alpha = 8'd2;             // primitive element

	// shift-and-add product, reduced by gf_poly after each shift
	function automatic gf_elem gf_mul(input gf_elem a, input gf_elem b);
		gf_elem product;
		logic [8:0] shifted;
		product = '0;
		shifted = {1'b0, a};
		for (int n = 0; n < 8; n++)
		begin
			if (b[n])
				product = product ^ shifted[7:0];
			shifted = shifted << 1;
			if (shifted[8])
				shifted = shifted ^ gf_poly;    // fold back into the field
		end
		return product;
	endfunction

	// a^254 = a^-1 for nonzero a, and zero maps to zero
	function automatic gf_elem gf_inv(input gf_elem a);
		gf_elem result;
		gf_elem square;
		result = 8'd1;
		square = a;
		for (int n = 1; n < 8; n++)
		begin
			square = gf_mul(square, square);    // a^(2^n)
			result = gf_mul(result, square);    // running product of a^2 .. a^128
		end
		return result;
	endfunction

endpackage

/* hdl/rs_pkg.sv */
package rs_pkg;

	localparam int codeword_length = 255;           // symbols per codeword, one Chien step each

	typedef logic [7:0] symbol_index;               // position in the codeword
	typedef logic [4:0] coef_index;                 // polynomial coefficient slot
	typedef logic [4:0] root_count;                 // locator roots found

	// decode phases of the search sequencer
	typedef enum logic [2:0]
	{
		seq_idle,
		seq_search,
		seq_drain,
		seq_output,
		seq_finish
	} seq_state;

endpackage

/* hdl/poly_eval_if.sv */
interface poly_eval_if;

	logic step_valid;                       // one-cycle strobe per evaluation
	rs_pkg::symbol_index step_index;        // codeword position of this step
	gf_pkg::gf_elem even_sum;               // even-index terms at alpha^i
	gf_pkg::gf_elem odd_sum;                // odd-index terms at alpha^i

	modport source
	(
		output step_valid,
		output step_index,
		output even_sum,
		output odd_sum
	);

	modport sink
	(
		input step_valid,
		input step_index,
		input even_sum,
		input odd_sum
	);

endinterface

/* hdl/poly_evaluator.sv */
module poly_evaluator
#(
	parameter int num_coefs = 19
)
(
	input logic clock,
	input logic reset,
	input logic clear_coefs,
	input logic coef_valid,
	input rs_pkg::coef_index coef_index,
	input gf_pkg::gf_elem coef,
	input logic step,
	poly_eval_if.source eval
);

	gf_pkg::gf_elem coefs [num_coefs];      // term k holds c_k * alpha^(i*k) at step i
	gf_pkg::gf_elem even_terms;
	gf_pkg::gf_elem odd_terms;
	rs_pkg::symbol_index step_count;

	// alpha^k, folded to a constant per coefficient slot
	function automatic gf_pkg::gf_elem alpha_power(input int k);
		gf_pkg::gf_elem power;
		power = 8'd1;
		for (int n = 0; n < k; n++)
			power = gf_pkg::gf_mul(power, gf_pkg::gf_alpha);
		return power;
	endfunction

	always_comb
	begin
		even_terms = '0;
		odd_terms = '0;
		for (int k = 0; k < num_coefs; k++)
		begin
			if (k % 2 == 0)
				even_terms = even_terms ^ coefs[k];
			else
				odd_terms = odd_terms ^ coefs[k];
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset || clear_coefs)
		begin
			for (int k = 0; k < num_coefs; k++)
				coefs[k] <= '0;
			step_count <= '0;
			eval.step_valid <= 1'b0;
		end
		else
		begin
			eval.step_valid <= step;
			if (coef_valid && coef_index < num_coefs)
				coefs[coef_index] <= coef;      // only reachable between decodes
			if (step)
			begin
				for (int k = 0; k < num_coefs; k++)
					coefs[k] <= gf_pkg::gf_mul(coefs[k], alpha_power(k));
				step_count <= step_count + 8'd1;
			end
		end
	end

	// sums of the current terms, registered alongside the strobe
	always_ff @(posedge clock)
	begin
		if (step)
		begin
			eval.step_index <= step_count;
			eval.even_sum <= even_terms;
			eval.odd_sum <= odd_terms;
		end
	end

endmodule

/* hdl/search_sequencer.sv */
module search_sequencer
(
	input logic clock,
	input logic reset,
	input logic start,
	output logic step,
	output logic clear_coefs,
	output logic emit,
	output logic busy,
	output rs_pkg::symbol_index emit_index,
	output logic done
);

	localparam rs_pkg::symbol_index last_index =
		rs_pkg::symbol_index'(rs_pkg::codeword_length - 1);

	rs_pkg::seq_state state;
	rs_pkg::symbol_index count;             // step, emit or finish cycle counter

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= rs_pkg::seq_idle;
			count <= '0;
		end
		else
		begin
			case (state)
				rs_pkg::seq_idle:
				begin
					count <= '0;
					if (start)
						state <= rs_pkg::seq_search;
				end
				rs_pkg::seq_search:
				begin
					count <= (count == last_index) ? '0 : count + 8'd1;
					if (count == last_index)
						state <= rs_pkg::seq_drain;
				end
				rs_pkg::seq_drain:
				begin
					state <= rs_pkg::seq_output;  // last evaluator result lands here
				end
				rs_pkg::seq_output:
				begin
					count <= (count == last_index) ? '0 : count + 8'd1;
					if (count == last_index)
						state <= rs_pkg::seq_finish;
				end
				rs_pkg::seq_finish:
				begin
					count <= count + 8'd1;
					if (count == 8'd1)
						state <= rs_pkg::seq_idle;
				end
				default:
					state <= rs_pkg::seq_idle;
			endcase
		end
	end

	assign step = (state == rs_pkg::seq_search);
	assign emit = (state == rs_pkg::seq_output);
	assign emit_index = count;
	assign busy = (state != rs_pkg::seq_idle);
	assign done = (state == rs_pkg::seq_finish) && (count == 8'd1);  // one cycle after last output
	assign clear_coefs = done;

endmodule

/* hdl/forney_corrector.sv */
module forney_corrector
(
	input logic clock,
	input logic reset,
	poly_eval_if.sink loc,
	poly_eval_if.sink mag,
	input logic symbol_valid,
	input rs_pkg::symbol_index symbol_index_in,
	input gf_pkg::gf_elem received_symbol,
	input rs_pkg::root_count locator_degree,
	input logic emit,
	input rs_pkg::symbol_index emit_index,
	input logic done,
	output logic out_valid,
	output rs_pkg::symbol_index out_index,
	output gf_pkg::gf_elem out_symbol,
	output logic decode_fail,
	output rs_pkg::root_count error_count
);

	localparam rs_pkg::symbol_index last_index =
		rs_pkg::symbol_index'(rs_pkg::codeword_length - 1);

	gf_pkg::gf_elem received_buf [rs_pkg::codeword_length];
	gf_pkg::gf_elem error_buf [rs_pkg::codeword_length];   // zero where no root

	gf_pkg::gf_elem sigma;
	gf_pkg::gf_elem omega;
	gf_pkg::gf_elem forney_value;
	rs_pkg::root_count root_total;
	rs_pkg::root_count root_next;
	logic root_hit;
	logic last_step;

	always_comb
	begin
		sigma = loc.even_sum ^ loc.odd_sum;     // locator at alpha^i
		omega = mag.even_sum ^ mag.odd_sum;
		forney_value = gf_pkg::gf_mul(omega, gf_pkg::gf_inv(loc.odd_sum));
		root_hit = loc.step_valid && (sigma == '0);
		root_next = root_total;
		if (root_hit && root_total != '1)
			root_next = root_total + 5'd1;      // saturates on a zero locator
		last_step = loc.step_valid && (loc.step_index == last_index);
	end

	// codeword load between decodes, error values during the search
	always_ff @(posedge clock)
	begin
		if (symbol_valid && symbol_index_in < rs_pkg::codeword_length)
			received_buf[symbol_index_in] <= received_symbol;
		if (mag.step_valid)
			error_buf[mag.step_index] <= (sigma == '0) ? forney_value : '0;
	end

	always_ff @(posedge clock)
	begin
		if (reset || done)
			root_total <= '0;                   // ready for the next search
		else if (loc.step_valid)
			root_total <= root_next;
	end

	// results settle as the search ends and hold through done
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			decode_fail <= 1'b0;
			error_count <= '0;
		end
		else if (last_step)
		begin
			decode_fail <= (root_next != locator_degree);
			error_count <= root_next;
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			out_valid <= 1'b0;
		else
			out_valid <= emit;
	end

	// one-cycle buffer read, failed decodes pass the codeword through
	always_ff @(posedge clock)
	begin
		if (emit)
		begin
			out_index <= emit_index;
			out_symbol <= received_buf[emit_index] ^
				(decode_fail ? 8'd0 : error_buf[emit_index]);
		end
	end

endmodule

/* hdl/chien_forney_top.sv */
module chien_forney_top
#(
	parameter int num_coefs = 19
)
(
	input logic clock,
	input logic reset,
	input logic coef_valid,
	input rs_pkg::coef_index coef_index,
	input gf_pkg::gf_elem locator_coef,
	input gf_pkg::gf_elem magnitude_coef,
	input logic symbol_valid,
	input rs_pkg::symbol_index symbol_index_in,
	input gf_pkg::gf_elem received_symbol,
	input logic start,
	input rs_pkg::root_count locator_degree,
	output logic out_valid,
	output rs_pkg::symbol_index out_index,
	output gf_pkg::gf_elem out_symbol,
	output logic done,
	output logic decode_fail,
	output rs_pkg::root_count error_count,
	output logic busy
);

	logic step;
	logic clear_coefs;
	logic emit;
	rs_pkg::symbol_index emit_index;

	poly_eval_if loc_eval();
	poly_eval_if mag_eval();

	search_sequencer u_search_sequencer
	(
		.clock          (clock),
		.reset          (reset),
		.start          (start),
		.step           (step),
		.clear_coefs    (clear_coefs),
		.emit           (emit),
		.busy           (busy),
		.emit_index     (emit_index),
		.done           (done)
	);

	poly_evaluator #(.num_coefs(num_coefs)) u_loc_eval
	(
		.clock          (clock),
		.reset          (reset),
		.clear_coefs    (clear_coefs),
		.coef_valid     (coef_valid && !busy),  // loads only between decodes
		.coef_index     (coef_index),
		.coef           (locator_coef),
		.step           (step),
		.eval           (loc_eval)
	);

	poly_evaluator #(.num_coefs(num_coefs)) u_mag_eval
	(
		.clock          (clock),
		.reset          (reset),
		.clear_coefs    (clear_coefs),
		.coef_valid     (coef_valid && !busy),
		.coef_index     (coef_index),
		.coef           (magnitude_coef),
		.step           (step),
		.eval           (mag_eval)
	);

	forney_corrector u_forney_corrector
	(
		.clock              (clock),
		.reset              (reset),
		.loc                (loc_eval),
		.mag                (mag_eval),
		.symbol_valid       (symbol_valid && !busy),
		.symbol_index_in    (symbol_index_in),
		.received_symbol    (received_symbol),
		.locator_degree     (locator_degree),
		.emit               (emit),
		.emit_index         (emit_index),
		.done               (done),
		.out_valid          (out_valid),
		.out_index          (out_index),
		.out_symbol         (out_symbol),
		.decode_fail        (decode_fail),
		.error_count        (error_count)
	);

endmodule

/* tb/tb_assertions.sv */
module tb_assertions
(
	input logic clock,
	input logic reset,
	input logic done,
	input logic out_valid,
	input logic busy
);

	timeunit 1ns;
	timeprecision 1ps;

	int failure_count = 0;

	done_one_cycle: assert property (@(posedge clock) disable iff (reset) done |=> !done)
		else
		begin
			failure_count++;
			$error("done stayed high for more than one cycle");
		end

	output_while_busy: assert property (@(posedge clock) disable iff (reset) out_valid |-> busy)
		else
		begin
			failure_count++;
			$error("out_valid high while not busy");
		end

	output_not_with_done: assert property (@(posedge clock) disable iff (reset)
		!(out_valid && done))
		else
		begin
			failure_count++;
			$error("out_valid and done high in the same cycle");
		end

endmodule

bind chien_forney_top tb_assertions u_tb_assertions
(
	.clock      (clock),
	.reset      (reset),
	.done       (done),
	.out_valid  (out_valid),
	.busy       (busy)
);

/* tb/tb_checker.sv */
module tb_checker
#(
	parameter int num_coefs = 19
)
(
	input logic clock, reset, coef_valid, symbol_valid, start,
	input logic out_valid, done, decode_fail, busy,
	input logic [4:0] coef_index, locator_degree, error_count,
	input logic [7:0] locator_coef, magnitude_coef, symbol_index_in, received_symbol,
	input logic [7:0] out_index, out_symbol,
	output int check_errors
);

	timeunit 1ns;
	timeprecision 1ps;

	logic [7:0] exp_table [256];            // alpha^n
	logic [7:0] log_table [256];
	logic [7:0] loc_model [num_coefs], mag_model [num_coefs];
	logic [7:0] rx_model [255], expected [255];
	int errors = 0, expected_roots = 0, next_index = 0;
	logic expected_fail = 1'b0, running = 1'b0, after_reset = 1'b0, last_out_valid = 1'b0;

	assign check_errors = errors;

	initial
	begin
		exp_table[0] = 8'h01;
		for (int n = 1; n < 256; n++)
			exp_table[n] = {exp_table[n - 1][6:0], 1'b0} ^ (exp_table[n - 1][7] ? 8'h1d : 8'h00);
		for (int n = 0; n < 255; n++)
			log_table[exp_table[n]] = 8'(n);
	end

	function automatic logic [7:0] field_mul(input logic [7:0] a, input logic [7:0] b);
		if (a == 8'h00 || b == 8'h00)
			return 8'h00;
		return exp_table[(int'(log_table[a]) + int'(log_table[b])) % 255];
	endfunction

	function automatic logic [7:0] field_inv(input logic [7:0] a);
		return (a == 8'h00) ? 8'h00 : exp_table[(255 - int'(log_table[a])) % 255];
	endfunction

	task automatic mismatch(input string name, input int expected_value, input int actual_value);
		errors++;
		$display("CHECK FAILED at %0t: %s expected %0h, actual %0h",
			$time, name, expected_value, actual_value);
	endtask

	task automatic complain(input string what);
		errors++;
		$display("ERROR at %0t: %s", $time, what);
	endtask

	// Chien search and Forney correction over the whole codeword
	task automatic predict();
		logic [7:0] power, even_sum, odd_sum, omega;
		expected_roots = 0;
		for (int i = 0; i < 255; i++)
		begin
			power = 8'h01;
			even_sum = 8'h00;
			odd_sum = 8'h00;
			omega = 8'h00;
			for (int k = 0; k < num_coefs; k++)
			begin
				if (k % 2 == 0)
					even_sum ^= field_mul(loc_model[k], power);
				else
					odd_sum ^= field_mul(loc_model[k], power);
				omega ^= field_mul(mag_model[k], power);
				power = field_mul(power, exp_table[i]);
			end
			expected[i] = rx_model[i];
			if (even_sum == odd_sum)        // locator root at alpha^i
			begin
				expected_roots++;
				expected[i] ^= field_mul(omega, field_inv(odd_sum));
			end
		end
		expected_fail = (expected_roots != int'(locator_degree));
		if (expected_fail)
			expected = rx_model;
	endtask

	task automatic finish_decode();
		if (!running)
			complain("done pulse arrived without a decode running");
		if (next_index != 255)
			complain($sformatf("decode ended after %0d output symbols, not 255", next_index));
		if (!last_out_valid)
			complain("done did not follow the last output symbol");
		if (error_count != expected_roots[4:0])
			mismatch("error_count", expected_roots, error_count);
		if (decode_fail != expected_fail)
			mismatch("decode_fail", expected_fail, decode_fail);
		running = 1'b0;
		loc_model = '{default: 8'h00};     // coefficients clear with done
		mag_model = '{default: 8'h00};
	endtask

	always @(negedge clock)
	begin
		if (reset)
		begin
			loc_model = '{default: 8'h00};
			mag_model = '{default: 8'h00};
			running = 1'b0;
			after_reset = 1'b1;
		end
		else
		begin
			if (after_reset && {busy, out_valid, done, decode_fail, error_count} != '0)
				mismatch("{busy,out_valid,done,decode_fail,error_count}", 0,
					{busy, out_valid, done, decode_fail, error_count});
			after_reset = 1'b0;
			if (coef_valid && !busy && coef_index < num_coefs)
			begin
				loc_model[coef_index] = locator_coef;
				mag_model[coef_index] = magnitude_coef;
			end
			if (symbol_valid && !busy && symbol_index_in != 8'hff)
				rx_model[symbol_index_in] = received_symbol;
			if (running && !busy)
				complain("busy dropped while a decode was running");
			if (start && !busy)
			begin
				predict();
				running = 1'b1;
				next_index = 0;
			end
			if (out_valid && (!running || next_index > 254))
				complain("output symbol outside a decode");
			else if (out_valid)
			begin
				if (out_index != 8'(next_index))
					mismatch("out_index", next_index, out_index);
				if (out_symbol != expected[next_index])
					mismatch($sformatf("out_symbol[%0d]", next_index),
						expected[next_index], out_symbol);
				next_index++;
			end
			if (done)
				finish_decode();
			last_out_valid = out_valid;
		end
	end

endmodule

/* tb/tb_top.sv */
module tb_top;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int num_coefs = 19;
	localparam int timeout_cycles = 1000;   // one decode takes 513 cycles

	logic clock, reset, coef_valid, symbol_valid, start;
	logic out_valid, done, decode_fail, busy;
	logic [4:0] coef_index, locator_degree, error_count;
	logic [7:0] locator_coef, magnitude_coef, symbol_index_in, received_symbol;
	logic [7:0] out_index, out_symbol;
	logic [7:0] locator [num_coefs];        // errata locator for the next decode
	int seed, check_errors, degree;
	int timeouts, errors_before, tests_run, tests_failed;

	chien_forney_top #(.num_coefs(num_coefs)) u_chien_forney_top (.*);
	tb_checker #(.num_coefs(num_coefs)) u_tb_checker (.*);

	initial
	begin
		clock = 1'b0;
		forever #20 clock = ~clock;         // 40 ns period
	end

	// one bit of b per round, top bit first
	function automatic logic [7:0] field_product(input logic [7:0] a, input logic [7:0] b);
		logic [7:0] result;
		result = 8'h00;
		for (int n = 7; n >= 0; n--)
			result = {result[6:0], 1'b0} ^ (result[7] ? 8'h1d : 8'h00) ^ (b[n] ? a : 8'h00);
		return result;
	endfunction

	// product of (1 + x alpha^-p) over distinct random positions p
	task automatic build_locator(input int roots);
		bit taken [255];
		int p;
		logic [7:0] beta;
		locator = '{default: 8'h00};
		locator[0] = 8'h01;
		for (int r = 0; r < roots; r++)
		begin
			p = $unsigned($random(seed)) % 255;
			while (taken[p])
				p = (p + 1) % 255;
			taken[p] = 1'b1;
			beta = 8'h01;
			for (int n = 0; n < (255 - p) % 255; n++)
				beta = field_product(beta, 8'h02);
			for (int k = num_coefs - 1; k > 0; k--)
				locator[k] = locator[k] ^ field_product(beta, locator[k - 1]);
		end
	endtask

	// coefficients ride along with the first codeword symbols
	task automatic decode(input int degree_in, input int loaded_coefs);
		int n;
		for (int i = 0; i < 255; i++)
		begin
			@(posedge clock);
			coef_valid <= (i < loaded_coefs);
			coef_index <= 5'(i);
			locator_coef <= locator[i % num_coefs];
			magnitude_coef <= 8'($random(seed));
			symbol_valid <= 1'b1;
			symbol_index_in <= 8'(i);
			received_symbol <= 8'($random(seed));
		end
		@(posedge clock);
		coef_valid <= 1'b0;
		symbol_valid <= 1'b0;
		start <= 1'b1;
		locator_degree <= 5'(degree_in);
		@(posedge clock);
		start <= 1'b0;
		n = 0;
		do
		begin
			@(negedge clock);
			n++;
		end
		while (!done && n < timeout_cycles);
		if (!done)
		begin
			timeouts++;
			$display("decode timed out, no done pulse within %0d cycles", timeout_cycles);
		end
		@(posedge clock);
	endtask

	task automatic report_test(input string name);
		int failures;
		failures = check_errors + timeouts - errors_before;
		tests_run++;
		if (failures != 0)
			tests_failed++;
		$display("test %0d %s: %s (%0d failures)", tests_run, name,
			(failures == 0) ? "ok" : "FAILED", failures);
		errors_before = check_errors + timeouts;
	endtask

	initial
	begin
		seed = 32'h413e;
		reset = 1'b1;
		coef_valid = 1'b0;
		coef_index = '0;
		locator_coef = '0;
		magnitude_coef = '0;
		symbol_valid = 1'b0;
		symbol_index_in = '0;
		received_symbol = '0;
		start = 1'b0;
		locator_degree = '0;
		timeouts = 0;
		errors_before = 0;
		tests_run = 0;
		tests_failed = 0;
		repeat (16) @(posedge clock);
		reset <= 1'b0;
		repeat (2) @(posedge clock);
		report_test("reset state");
		degree = 1 + $unsigned($random(seed)) % 9;
		build_locator(degree);
		decode(degree, num_coefs);
		report_test("random errata");
		decode(degree + 1, num_coefs);      // same locator, degree off by one
		report_test("degree mismatch");
		build_locator(0);
		decode(0, num_coefs);
		report_test("error free");
		for (int d = 0; d < 2; d++)
		begin
			degree = 1 + $unsigned($random(seed)) % 9;
			build_locator(degree);
			decode(degree, (d == 0) ? num_coefs : degree + 1);  // high slots rely on the clear
		end
		report_test("back to back");
		$display("tests run %0d, failed %0d, check errors %0d, timeouts %0d, assertion failures %0d",
			tests_run, tests_failed, check_errors, timeouts,
			u_chien_forney_top.u_tb_assertions.failure_count);
		if (tests_failed == 0 && check_errors == 0 && timeouts == 0 &&
			u_chien_forney_top.u_tb_assertions.failure_count == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

/* build.f */
hdl/gf_pkg.sv
hdl/rs_pkg.sv
hdl/poly_eval_if.sv
hdl/poly_evaluator.sv
hdl/search_sequencer.sv
hdl/forney_corrector.sv
hdl/chien_forney_top.sv
tb/tb_assertions.sv
tb/tb_checker.sv
tb/tb_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the Chien/Forney testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_top \
	-Mdir "$build_dir" -o tb_sim
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

"./$build_dir/tb_sim" +verilator+error+limit+1000 > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -Fqx 'All tests passed!' "$log_file"; then
	echo "PASS"
	exit 0
fi
echo "FAIL"
exit 1
